/* hw/procPkg.sv */
// ##########################################################
// proc shared definitions: widths, opcodes, function codes
// and the payload carried by each pipeline latch
// ##########################################################
package procPkg;

  localparam int dataW    = 16;
  localparam int regAddrW = 3;
  localparam int numRegs  = 8;

  // opcode lives in instr[15:11]
  // the all-zero word is ADDI r0, r0, 0 so an IF/ID bubble does nothing
  localparam logic [4:0] opAddi = 5'b00000;
  localparam logic [4:0] opHalt = 5'b00001;
  localparam logic [4:0] opBeqz = 5'b01100;
  localparam logic [4:0] opSt   = 5'b10000;
  localparam logic [4:0] opLd   = 5'b10001;
  localparam logic [4:0] opLbi  = 5'b11000;
  localparam logic [4:0] opAlu  = 5'b11011;

  // function field of the ALU format, instr[1:0]
  localparam logic [1:0] fnAdd = 2'b00;
  localparam logic [1:0] fnSub = 2'b01;
  localparam logic [1:0] fnXor = 2'b10;
  localparam logic [1:0] fnAnd = 2'b11;

  typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluXor} aluOpT;

  typedef struct packed {
    logic [dataW-1:0] instr;
    logic [dataW-1:0] nextPc;
  } ifIdT;

  typedef struct packed {
    logic [dataW-1:0]    a;
    logic [dataW-1:0]    b;
    logic [dataW-1:0]    imm;
    logic [regAddrW-1:0] rs;
    logic [regAddrW-1:0] rt;
    logic [regAddrW-1:0] dest;
    logic                readsRs;
    logic                readsRt;
    logic                regWrite;
    logic                memRead;
    logic                memWrite;
    logic                useImm;
    logic                isBranch;
    logic                halt;
    logic                illegal;
    aluOpT               aluOp;
    logic [dataW-1:0]    nextPc;
  } idExT;

  typedef struct packed {
    logic [dataW-1:0]    aluResult;
    logic [dataW-1:0]    storeData;  // forwarded rt for ST
    logic [regAddrW-1:0] dest;
    logic                regWrite;
    logic                memRead;
    logic                memWrite;
    logic                halt;
    logic                illegal;
  } exMemT;

  typedef struct packed {
    logic [dataW-1:0]    result;
    logic [regAddrW-1:0] dest;
    logic                regWrite;
    logic                halt;
    logic                illegal;
  } memWbT;

endpackage

/* hw/pipeStage.sv */
// ##########################################################
// pipeline latch between two stages, generic over payload
// ##########################################################
`timescale 1ns/1ps

module pipeStage #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    en,
  input  logic    flush,
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk) begin
    if (rst) begin
      q <= '0;
    end else if (en) begin
      q <= flush ? payloadT'('0) : d;  // flush only lands when the stage moves
    end
  end

endmodule

/* hw/fetchUnit.sv */
// ##########################################################
// fetch: PC register, next-PC select, sticky halt and error
// ##########################################################
`timescale 1ns/1ps

module fetchUnit (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      hold,
  input  logic                      memStall,
  input  logic                      branchTaken,
  input  logic [procPkg::dataW-1:0] branchTarget,
  input  logic                      wbHalt,
  input  logic                      wbIllegal,
  output logic [procPkg::dataW-1:0] pc,
  output logic [procPkg::dataW-1:0] nextPc,
  output logic                      halted,
  output logic                      err
);

  assign nextPc = pc + 16'd2;  // byte addressed, 2-byte instructions

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (memStall || halted) begin
      pc <= pc;
    end else if (branchTaken) begin
      pc <= branchTarget;
    end else if (!hold) begin
      pc <= nextPc;
    end
  end

  // status bits stay set until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      halted <= 1'b0;
      err    <= 1'b0;
    end else begin
      halted <= halted || wbHalt;
      err    <= err || wbIllegal;
    end
  end

endmodule

/* hw/regFile.sv */
// ##########################################################
// register file: 8 x 16, two reads, one write, with bypass
// ##########################################################
`timescale 1ns/1ps

module regFile (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [procPkg::regAddrW-1:0] rdAddrA,
  input  logic [procPkg::regAddrW-1:0] rdAddrB,
  input  logic [procPkg::regAddrW-1:0] wrAddr,
  input  logic                         wrEn,
  input  logic [procPkg::dataW-1:0]    wrData,
  output logic [procPkg::dataW-1:0]    rdDataA,
  output logic [procPkg::dataW-1:0]    rdDataB
);

  logic [procPkg::dataW-1:0] regs [procPkg::numRegs];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < procPkg::numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  // writeback in the same cycle wins over the stored value
  assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
  assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

/* hw/decodeControl.sv */
// ##########################################################
// decode: fields, immediates and control flags per opcode
// ##########################################################
`timescale 1ns/1ps

module decodeControl (
  input  logic [procPkg::dataW-1:0]    instr,
  output logic [procPkg::dataW-1:0]    imm,
  output logic [procPkg::regAddrW-1:0] rsAddr,
  output logic [procPkg::regAddrW-1:0] rtAddr,
  output logic [procPkg::regAddrW-1:0] dest,
  output logic                         readsRs,
  output logic                         readsRt,
  output logic                         regWrite,
  output logic                         memRead,
  output logic                         memWrite,
  output logic                         useImm,
  output logic                         isBranch,
  output logic                         halt,
  output logic                         illegal,
  output procPkg::aluOpT               aluOp
);

  logic [4:0]                opcode;
  logic [procPkg::dataW-1:0] imm5;
  logic [procPkg::dataW-1:0] imm8;

  assign opcode = instr[15:11];
  assign rsAddr = instr[10:8];
  assign rtAddr = instr[7:5];
  assign imm5   = {{11{instr[4]}}, instr[4:0]};
  assign imm8   = {{8{instr[7]}}, instr[7:0]};

  always_comb begin
    readsRs  = 1'b0;
    readsRt  = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    useImm   = 1'b0;
    isBranch = 1'b0;
    halt     = 1'b0;
    illegal  = 1'b0;
    dest     = rtAddr;
    imm      = imm5;
    aluOp    = procPkg::aluAdd;
    case (opcode)
      procPkg::opAddi: begin
        readsRs  = 1'b1;
        regWrite = 1'b1;
        useImm   = 1'b1;
      end
      procPkg::opLbi: begin
        regWrite = 1'b1;
        useImm   = 1'b1;
        dest     = rsAddr;  // LBI writes its rs field
        imm      = imm8;
      end
      procPkg::opLd: begin
        readsRs  = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
        useImm   = 1'b1;
      end
      procPkg::opSt: begin
        readsRs  = 1'b1;
        readsRt  = 1'b1;  // store data
        memWrite = 1'b1;
        useImm   = 1'b1;
      end
      procPkg::opBeqz: begin
        readsRs  = 1'b1;
        isBranch = 1'b1;
        imm      = imm8;
      end
      procPkg::opAlu: begin
        readsRs  = 1'b1;
        readsRt  = 1'b1;
        regWrite = 1'b1;
        dest     = instr[4:2];
        case (instr[1:0])
          procPkg::fnAdd: aluOp = procPkg::aluAdd;
          procPkg::fnSub: aluOp = procPkg::aluSub;
          procPkg::fnAnd: aluOp = procPkg::aluAnd;
          procPkg::fnXor: aluOp = procPkg::aluXor;
        endcase
      end
      procPkg::opHalt: halt = 1'b1;
      default: begin
        halt    = 1'b1;  // unknown opcode stops like HALT
        illegal = 1'b1;
      end
    endcase
  end

endmodule

/* hw/hazardUnit.sv */
// ##########################################################
// hazard detect: load-use stall and HALT fetch hold
// ##########################################################
`timescale 1ns/1ps

module hazardUnit (
  input  logic [procPkg::regAddrW-1:0] idRs,
  input  logic [procPkg::regAddrW-1:0] idRt,
  input  logic                         idReadsRs,
  input  logic                         idReadsRt,
  input  logic                         idHalt,
  input  logic                         exMemRead,
  input  logic [procPkg::regAddrW-1:0] exDest,
  input  logic                         branchTaken,
  output logic                         hold,
  output logic                         bubbleEx
);

  logic loadUse;

  // load in EX feeding the instruction in ID
  assign loadUse = exMemRead &&
                   ((idReadsRs && idRs == exDest) || (idReadsRt && idRt == exDest));

  // a taken branch flushes ID anyway
  assign hold     = !branchTaken && (loadUse || idHalt);
  assign bubbleEx = !branchTaken && loadUse;

endmodule

/* hw/forwardUnit.sv */
// ##########################################################
// forwarding: picks EX operands from EX/MEM, MEM/WB or ID/EX
// ##########################################################
`timescale 1ns/1ps

module forwardUnit (
  input  logic [procPkg::regAddrW-1:0] exRs,
  input  logic [procPkg::regAddrW-1:0] exRt,
  input  logic                         exReadsRs,
  input  logic                         exReadsRt,
  input  logic [procPkg::dataW-1:0]    operandA,
  input  logic [procPkg::dataW-1:0]    operandB,
  input  logic [procPkg::regAddrW-1:0] memDest,
  input  logic                         memRegWrite,
  input  logic [procPkg::dataW-1:0]    memResult,
  input  logic [procPkg::regAddrW-1:0] wbDest,
  input  logic                         wbRegWrite,
  input  logic [procPkg::dataW-1:0]    wbResult,
  output logic [procPkg::dataW-1:0]    chosenA,
  output logic [procPkg::dataW-1:0]    chosenB
);

  // youngest producer first
  function automatic logic [procPkg::dataW-1:0] pick(
    input logic [procPkg::regAddrW-1:0] src,
    input logic                         reads,
    input logic [procPkg::dataW-1:0]    latched
  );
    if (reads && memRegWrite && memDest == src) return memResult;
    if (reads && wbRegWrite && wbDest == src) return wbResult;
    return latched;
  endfunction

  assign chosenA = pick(exRs, exReadsRs, operandA);
  assign chosenB = pick(exRt, exReadsRt, operandB);

endmodule

/* hw/execAlu.sv */
// ##########################################################
// execute: ALU, BEQZ condition and branch target
// ##########################################################
`timescale 1ns/1ps

module execAlu (
  input  procPkg::idExT             idEx,
  output logic [procPkg::dataW-1:0] aluResult,
  output logic [procPkg::dataW-1:0] storeData,
  output logic [procPkg::dataW-1:0] branchTarget,
  output logic                      branchTaken
);

  logic [procPkg::dataW-1:0] opA;
  logic [procPkg::dataW-1:0] opB;

  // LBI reads no rs, so A is zero and the immediate passes through
  assign opA = idEx.readsRs ? idEx.a : '0;
  assign opB = idEx.useImm ? idEx.imm : idEx.b;

  always_comb begin
    case (idEx.aluOp)
      procPkg::aluSub: aluResult = opA - opB;
      procPkg::aluAnd: aluResult = opA & opB;
      procPkg::aluXor: aluResult = opA ^ opB;
      default:         aluResult = opA + opB;  // ADD, ADDI, LBI, address calc
    endcase
  end

  assign storeData    = idEx.b;
  assign branchTaken  = idEx.isBranch && (idEx.a == '0);
  assign branchTarget = idEx.nextPc + idEx.imm;

endmodule

/* hw/memAccess.sv */
// ##########################################################
// memory stage: four-phase req/ack master to data memory
// ##########################################################
`timescale 1ns/1ps

module memAccess (
  input  logic                      clk,
  input  logic                      rst,
  input  procPkg::exMemT            exMem,
  input  logic                      dmemAck,
  input  logic [procPkg::dataW-1:0] dmemRdata,
  output logic                      dmemReq,
  output logic                      dmemWe,
  output logic [procPkg::dataW-1:0] dmemAddr,
  output logic [procPkg::dataW-1:0] dmemWdata,
  output logic                      memStall,
  output logic [procPkg::dataW-1:0] result
);

  typedef enum logic [1:0] {stIdle, stRequest, stRelease, stDone} stateT;

  stateT                     state;
  stateT                     stateNext;
  logic                      memOp;
  logic [procPkg::dataW-1:0] rdataQ;

  assign memOp = exMem.memRead || exMem.memWrite;

  always_comb begin
    stateNext = state;
    case (state)
      stIdle:    if (memOp) stateNext = stRequest;
      stRequest: if (dmemAck) stateNext = stRelease;
      stRelease: if (!dmemAck) stateNext = stDone;  // ack back low
      default:   stateNext = stIdle;  // done, latches move past the op
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= stIdle;
    end else begin
      state <= stateNext;
    end
  end

  // read data valid only while ack is high
  always_ff @(posedge clk) begin
    if (state == stRequest && dmemAck) begin
      rdataQ <= dmemRdata;
    end
  end

  assign dmemReq   = (state == stRequest);
  assign dmemWe    = exMem.memWrite;
  assign dmemAddr  = exMem.aluResult;
  assign dmemWdata = exMem.storeData;  // EX/MEM frozen, so stable under req

  assign memStall = (state == stIdle && memOp) || state == stRequest || state == stRelease;
  assign result   = exMem.memRead ? rdataQ : exMem.aluResult;

endmodule

/* hw/proc.sv */
// ##########################################################
// proc: 16-bit five-stage pipeline with external memories
// ##########################################################
`timescale 1ns/1ps

module proc (
  input  logic                      clk,
  input  logic                      rst,
  output logic [procPkg::dataW-1:0] imemAddr,
  input  logic [procPkg::dataW-1:0] imemData,
  output logic                      dmemReq,
  output logic                      dmemWe,
  output logic [procPkg::dataW-1:0] dmemAddr,
  output logic [procPkg::dataW-1:0] dmemWdata,
  input  logic                      dmemAck,
  input  logic [procPkg::dataW-1:0] dmemRdata,
  output logic                      halted,
  output logic                      err
);

  procPkg::ifIdT  ifIdD, ifIdQ;
  procPkg::idExT  idExD, idExQ, exIn;
  procPkg::exMemT exMemD, exMemQ;
  procPkg::memWbT memWbD, memWbQ;

  logic [procPkg::dataW-1:0]    nextPc, branchTarget, aluResult, storeData, memResult;
  logic [procPkg::dataW-1:0]    rdDataA, rdDataB, chosenA, chosenB, idImm;
  logic [procPkg::regAddrW-1:0] idRs, idRt, idDest;
  logic idReadsRs, idReadsRt, idRegWrite, idMemRead, idMemWrite;
  logic idUseImm, idIsBranch, idHalt, idIllegal;
  logic hold, bubbleEx, branchTaken, memStall;
  procPkg::aluOpT idAluOp;

  fetchUnit u_fetch (
    .clk(clk), .rst(rst), .hold(hold), .memStall(memStall),
    .branchTaken(branchTaken), .branchTarget(branchTarget),
    .wbHalt(memWbQ.halt), .wbIllegal(memWbQ.illegal),
    .pc(imemAddr), .nextPc(nextPc), .halted(halted), .err(err)
  );

  assign ifIdD = '{instr: imemData, nextPc: nextPc};

  pipeStage #(.payloadT(procPkg::ifIdT)) u_ifId (
    .clk(clk), .rst(rst), .en(!(hold || memStall)), .flush(branchTaken),
    .d(ifIdD), .q(ifIdQ)
  );

  decodeControl u_decode (
    .instr(ifIdQ.instr), .imm(idImm), .rsAddr(idRs), .rtAddr(idRt), .dest(idDest),
    .readsRs(idReadsRs), .readsRt(idReadsRt), .regWrite(idRegWrite),
    .memRead(idMemRead), .memWrite(idMemWrite), .useImm(idUseImm),
    .isBranch(idIsBranch), .halt(idHalt), .illegal(idIllegal), .aluOp(idAluOp)
  );

  // writeback straight from MEM/WB
  regFile u_regFile (
    .clk(clk), .rst(rst), .rdAddrA(idRs), .rdAddrB(idRt),
    .wrAddr(memWbQ.dest), .wrEn(memWbQ.regWrite), .wrData(memWbQ.result),
    .rdDataA(rdDataA), .rdDataB(rdDataB)
  );

  hazardUnit u_hazard (
    .idRs(idRs), .idRt(idRt), .idReadsRs(idReadsRs), .idReadsRt(idReadsRt),
    .idHalt(idHalt), .exMemRead(idExQ.memRead), .exDest(idExQ.dest),
    .branchTaken(branchTaken), .hold(hold), .bubbleEx(bubbleEx)
  );

  assign idExD = '{a: rdDataA, b: rdDataB, imm: idImm, rs: idRs, rt: idRt, dest: idDest,
                   readsRs: idReadsRs, readsRt: idReadsRt, regWrite: idRegWrite,
                   memRead: idMemRead, memWrite: idMemWrite, useImm: idUseImm,
                   isBranch: idIsBranch, halt: idHalt, illegal: idIllegal,
                   aluOp: idAluOp, nextPc: ifIdQ.nextPc};

  pipeStage #(.payloadT(procPkg::idExT)) u_idEx (
    .clk(clk), .rst(rst), .en(!memStall), .flush(bubbleEx || branchTaken),
    .d(idExD), .q(idExQ)
  );

  forwardUnit u_forward (
    .exRs(idExQ.rs), .exRt(idExQ.rt), .exReadsRs(idExQ.readsRs), .exReadsRt(idExQ.readsRt),
    .operandA(idExQ.a), .operandB(idExQ.b),
    .memDest(exMemQ.dest), .memRegWrite(exMemQ.regWrite), .memResult(exMemQ.aluResult),
    .wbDest(memWbQ.dest), .wbRegWrite(memWbQ.regWrite), .wbResult(memWbQ.result),
    .chosenA(chosenA), .chosenB(chosenB)
  );

  // forwarded operands replace the latched ones
  assign exIn = '{a: chosenA, b: chosenB, imm: idExQ.imm, rs: idExQ.rs, rt: idExQ.rt,
                  dest: idExQ.dest, readsRs: idExQ.readsRs, readsRt: idExQ.readsRt,
                  regWrite: idExQ.regWrite, memRead: idExQ.memRead,
                  memWrite: idExQ.memWrite, useImm: idExQ.useImm,
                  isBranch: idExQ.isBranch, halt: idExQ.halt, illegal: idExQ.illegal,
                  aluOp: idExQ.aluOp, nextPc: idExQ.nextPc};

  execAlu u_exec (
    .idEx(exIn), .aluResult(aluResult), .storeData(storeData),
    .branchTarget(branchTarget), .branchTaken(branchTaken)
  );

  assign exMemD = '{aluResult: aluResult, storeData: storeData, dest: idExQ.dest,
                    regWrite: idExQ.regWrite, memRead: idExQ.memRead,
                    memWrite: idExQ.memWrite, halt: idExQ.halt, illegal: idExQ.illegal};

  pipeStage #(.payloadT(procPkg::exMemT)) u_exMem (
    .clk(clk), .rst(rst), .en(!memStall), .flush(1'b0), .d(exMemD), .q(exMemQ)
  );

  memAccess u_mem (
    .clk(clk), .rst(rst), .exMem(exMemQ), .dmemAck(dmemAck), .dmemRdata(dmemRdata),
    .dmemReq(dmemReq), .dmemWe(dmemWe), .dmemAddr(dmemAddr), .dmemWdata(dmemWdata),
    .memStall(memStall), .result(memResult)
  );

  assign memWbD = '{result: memResult, dest: exMemQ.dest, regWrite: exMemQ.regWrite,
                    halt: exMemQ.halt, illegal: exMemQ.illegal};

  pipeStage #(.payloadT(procPkg::memWbT)) u_memWb (
    .clk(clk), .rst(rst), .en(!memStall), .flush(1'b0), .d(memWbD), .q(memWbQ)
  );

endmodule

/* tests/procTb.sv */
// ##########################################################
// procTb: directed tests for the proc pipeline, with a
// same-cycle instruction memory and a req/ack data memory
// ##########################################################
`timescale 1ns/1ps

module procTb;

  localparam int          timeoutCycles = 2000;
  localparam logic [31:0] seedValue     = 32'hcb79_ce22;
  localparam logic [15:0] haltWord      = {procPkg::opHalt, 11'd0};

  logic        clk       = 1'b0;
  logic        rst       = 1'b1;
  logic [15:0] imemAddr;
  logic [15:0] imemData;
  logic        dmemReq;
  logic        dmemWe;
  logic [15:0] dmemAddr;
  logic [15:0] dmemWdata;
  logic        dmemAck   = 1'b0;
  logic [15:0] dmemRdata = 16'h0000;
  logic        halted;
  logic        err;

  logic [15:0] imem [64];
  logic [15:0] imemIndex;
  logic [5:0]  progLen;
  logic [15:0] dmem [logic [15:0]];
  logic [15:0] logAddr [$];  // every write the responder took
  logic [15:0] logData [$];
  logic [15:0] expAddr [$];
  logic [15:0] expData [$];
  bit          ackRandom = 1'b0;
  integer      seed      = seedValue;
  int          delayLeft;
  bit          waiting;
  bit          ackDue;
  logic        prevReq;
  logic        prevWe;
  logic [15:0] prevAddr;
  logic [15:0] prevWdata;

  proc u_proc (
    .clk(clk), .rst(rst), .imemAddr(imemAddr), .imemData(imemData),
    .dmemReq(dmemReq), .dmemWe(dmemWe), .dmemAddr(dmemAddr), .dmemWdata(dmemWdata),
    .dmemAck(dmemAck), .dmemRdata(dmemRdata), .halted(halted), .err(err)
  );

  always #5 clk = ~clk;

  assign imemIndex = imemAddr >> 1;  // PC counts bytes
  assign imemData  = imem[imemIndex[5:0]];

  task automatic stopRun();
    $display("sim failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkEq(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      stopRun();
    end
  endtask

  task automatic failNow(input string why);
    $display("error at t=%0t: %s", $time, why);
    stopRun();
  endtask

  // unwritten words read back as a pattern of the full address
  function automatic logic [15:0] fillWord(input logic [15:0] a);
    return {a[7:0], a[15:8]} ^ 16'h5ac3;
  endfunction

  function automatic logic [15:0] fiveBitSigned(input logic [4:0] v);
    return {{11{v[4]}}, v};
  endfunction

  function automatic logic [15:0] byteSigned(input logic [7:0] v);
    return {{8{v[7]}}, v};
  endfunction

  function automatic logic [15:0] lbiWord(input logic [2:0] rd, input logic [7:0] imm);
    return {procPkg::opLbi, rd, imm};
  endfunction

  function automatic logic [15:0] addiWord(input logic [2:0] rt, input logic [2:0] rs,
                                           input logic [4:0] imm);
    return {procPkg::opAddi, rs, rt, imm};
  endfunction

  function automatic logic [15:0] aluWord(input logic [2:0] rd, input logic [2:0] rs,
                                          input logic [2:0] rt, input logic [1:0] fn);
    return {procPkg::opAlu, rs, rt, rd, fn};
  endfunction

  function automatic logic [15:0] storeWord(input logic [2:0] rt, input logic [2:0] rs,
                                            input logic [4:0] off);
    return {procPkg::opSt, rs, rt, off};
  endfunction

  function automatic logic [15:0] loadWord(input logic [2:0] rt, input logic [2:0] rs,
                                           input logic [4:0] off);
    return {procPkg::opLd, rs, rt, off};
  endfunction

  function automatic logic [15:0] beqzWord(input logic [2:0] rs, input logic [7:0] off);
    return {procPkg::opBeqz, rs, off};
  endfunction

  // random wait in cycles before ack moves
  task automatic countDelay(output bit due);
    if (!waiting) begin
      waiting   = 1'b1;
      delayLeft = ackRandom ? ($random(seed) & 3) : 0;
    end
    due = (delayLeft == 0);
    if (due) begin
      waiting = 1'b0;
    end else begin
      delayLeft = delayLeft - 1;
    end
  endtask

  // data memory responder that also watches the four-phase protocol
  always @(negedge clk) begin
    if (rst) begin
      dmemAck = 1'b0;
      waiting = 1'b0;
      prevReq = 1'b0;
      logAddr.delete();
      logData.delete();
      dmem.delete();
    end else begin
      if (dmemReq && !prevReq && dmemAck) begin
        failNow("dmemReq rose before dmemAck had returned low");
      end
      if (dmemReq && prevReq) begin  // request fields must hold
        checkEq("dmemAddr", prevAddr, dmemAddr);
        checkEq("dmemWe", 16'(prevWe), 16'(dmemWe));
        checkEq("dmemWdata", prevWdata, dmemWdata);
      end
      prevReq   = dmemReq;
      prevWe    = dmemWe;
      prevAddr  = dmemAddr;
      prevWdata = dmemWdata;
      if (dmemReq && !dmemAck) begin
        countDelay(ackDue);
        if (ackDue) begin
          dmemAck = 1'b1;
          if (dmemWe) begin
            dmem[dmemAddr] = dmemWdata;
            logAddr.push_back(dmemAddr);
            logData.push_back(dmemWdata);
          end else begin
            dmemRdata = dmem.exists(dmemAddr) ? dmem[dmemAddr] : fillWord(dmemAddr);
          end
        end
      end else if (!dmemReq && dmemAck) begin
        countDelay(ackDue);  // release may lag as well
        if (ackDue) begin
          dmemAck   = 1'b0;
          dmemRdata = 16'hbad0;  // junk once ack is gone
        end
      end
    end
  end

  task automatic startProgram();
    for (int i = 0; i < 64; i++) begin
      imem[i] = haltWord;
    end
    progLen = 6'd0;
    expAddr.delete();
    expData.delete();
  endtask

  task automatic emit(input logic [15:0] word);
    imem[progLen] = word;
    progLen = progLen + 6'd1;
  endtask

  task automatic expectStore(input logic [15:0] addr, input logic [15:0] data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  task automatic runProgram(input bit randomAck);
    int cycles;
    @(negedge clk);
    ackRandom = randomAck;
    rst = 1'b1;
    repeat (5) @(negedge clk);
    checkEq("imemAddr", 16'h0000, imemAddr);  // state right out of reset
    checkEq("dmemReq", 16'd0, 16'(dmemReq));
    checkEq("halted", 16'd0, 16'(halted));
    checkEq("err", 16'd0, 16'(err));
    rst = 1'b0;
    cycles = 0;
    while (!halted && cycles < timeoutCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      failNow("program did not reach halted in time");
    end
    repeat (8) @(negedge clk);  // a stray store would show up here
  endtask

  task automatic checkStores();
    checkEq("store count", 16'(expAddr.size()), 16'(logAddr.size()));
    foreach (expAddr[i]) begin
      checkEq("dmemAddr", expAddr[i], logAddr[i]);
      checkEq("dmemWdata", expData[i], logData[i]);
    end
  endtask

  task automatic aluForwarding(input bit randomAck);
    logic [15:0] r1, r2, r3, r4, r5, r6, r7, base;
    startProgram();
    emit(lbiWord(3'd0, 8'h20));
    emit(lbiWord(3'd1, 8'h35));
    emit(lbiWord(3'd2, 8'hfa));
    emit(addiWord(3'd3, 3'd1, 5'h1d));
    emit(aluWord(3'd4, 3'd1, 3'd2, procPkg::fnAdd));
    emit(aluWord(3'd5, 3'd4, 3'd3, procPkg::fnSub));
    emit(aluWord(3'd6, 3'd5, 3'd1, procPkg::fnAnd));
    emit(aluWord(3'd7, 3'd6, 3'd2, procPkg::fnXor));
    emit(storeWord(3'd3, 3'd0, 5'd0));
    emit(storeWord(3'd4, 3'd0, 5'd2));
    emit(storeWord(3'd5, 3'd0, 5'd4));
    emit(storeWord(3'd6, 3'd0, 5'd6));
    emit(storeWord(3'd7, 3'd0, 5'd8));
    emit(haltWord);
    base = byteSigned(8'h20);
    r1   = byteSigned(8'h35);
    r2   = byteSigned(8'hfa);
    r3   = r1 + fiveBitSigned(5'h1d);
    r4   = r1 + r2;
    r5   = r4 - r3;
    r6   = r5 & r1;
    r7   = r6 ^ r2;
    expectStore(base, r3);
    expectStore(base + 16'd2, r4);
    expectStore(base + 16'd4, r5);
    expectStore(base + 16'd6, r6);
    expectStore(base + 16'd8, r7);
    runProgram(randomAck);
    checkStores();
  endtask

  task automatic loadUse(input bit randomAck);
    logic [15:0] base, r1, r3;
    startProgram();
    emit(lbiWord(3'd0, 8'h40));
    emit(lbiWord(3'd1, 8'h5b));
    emit(storeWord(3'd1, 3'd0, 5'd4));
    emit(loadWord(3'd2, 3'd0, 5'd4));
    emit(addiWord(3'd3, 3'd2, 5'd7));  // uses the load right away
    emit(storeWord(3'd3, 3'd0, 5'd6));
    emit(loadWord(3'd4, 3'd0, 5'h0c));
    emit(storeWord(3'd4, 3'd0, 5'd8));  // store data straight from a load
    emit(haltWord);
    base = byteSigned(8'h40);
    r1   = byteSigned(8'h5b);
    r3   = r1 + fiveBitSigned(5'd7);
    expectStore(base + 16'd4, r1);
    expectStore(base + 16'd6, r3);
    expectStore(base + 16'd8, fillWord(base + fiveBitSigned(5'h0c)));
    runProgram(randomAck);
    checkStores();
  endtask

  task automatic branchSkip(input bit randomAck);
    logic [15:0] base, r1, r2;
    startProgram();
    emit(lbiWord(3'd2, 8'h09));
    emit(lbiWord(3'd0, 8'h60));
    emit(lbiWord(3'd1, 8'h00));
    emit(beqzWord(3'd1, 8'd4));  // over the next two words
    emit(storeWord(3'd2, 3'd0, 5'd0));
    emit(storeWord(3'd2, 3'd0, 5'd2));
    emit(storeWord(3'd2, 3'd0, 5'd4));
    emit(beqzWord(3'd2, 8'd4));
    emit(storeWord(3'd1, 3'd0, 5'd6));
    emit(storeWord(3'd2, 3'd0, 5'd8));
    emit(haltWord);
    base = byteSigned(8'h60);
    r1   = byteSigned(8'h00);
    r2   = byteSigned(8'h09);
    if (r1 != 16'd0) begin
      expectStore(base, r2);
      expectStore(base + 16'd2, r2);
    end
    expectStore(base + 16'd4, r2);
    if (r2 != 16'd0) begin
      expectStore(base + 16'd6, r1);
      expectStore(base + 16'd8, r2);
    end
    runProgram(randomAck);
    checkStores();
  endtask

  task automatic haltStop();
    startProgram();
    emit(lbiWord(3'd0, 8'h70));
    emit(lbiWord(3'd1, 8'h11));
    emit(storeWord(3'd1, 3'd0, 5'd0));
    emit(haltWord);
    emit(storeWord(3'd1, 3'd0, 5'd2));  // never issued
    expectStore(byteSigned(8'h70), byteSigned(8'h11));
    runProgram(1'b0);
    checkStores();
    checkEq("halted", 16'd1, 16'(halted));
    checkEq("err", 16'd0, 16'(err));
  endtask

  task automatic illegalOpcode();
    startProgram();
    emit(lbiWord(3'd0, 8'h70));
    emit(lbiWord(3'd1, 8'h22));
    emit(storeWord(3'd1, 3'd0, 5'd0));
    emit({5'b11111, 11'd0});  // opcode with no meaning
    emit(storeWord(3'd1, 3'd0, 5'd2));
    expectStore(byteSigned(8'h70), byteSigned(8'h22));
    runProgram(1'b0);
    checkStores();
    checkEq("halted", 16'd1, 16'(halted));
    checkEq("err", 16'd1, 16'(err));
  endtask

  initial begin
    aluForwarding(1'b0);
    loadUse(1'b0);
    branchSkip(1'b0);
    aluForwarding(1'b1);  // same programs under random ack delays
    loadUse(1'b1);
    branchSkip(1'b1);
    haltStop();
    illegalOpcode();
    $display("sim passed");
    $finish;
  end

endmodule

/* proc.f */
hw/procPkg.sv
hw/pipeStage.sv
hw/fetchUnit.sv
hw/regFile.sv
hw/decodeControl.sv
hw/hazardUnit.sv
hw/forwardUnit.sv
hw/execAlu.sv
hw/memAccess.sv
hw/proc.sv
tests/procTb.sv

/* run.sh */
#!/bin/sh
# build proc and its testbench with Verilator, run it, then judge the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing -sv --top-module procTb -f proc.f -Mdir obj_dir -o procSim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/procSim > sim.log 2>&1 || echo "simulator exited with an error status" >> sim.log
cat sim.log
# the testbench prints its fail line before it stops
grep -q "sim failed" sim.log && exit 1 || grep -q "sim passed" sim.log || exit 1
exit 0
